//--- hdl/fetch_pkg.sv
//----------------------------------------------------------------------
// Fetch stage package
// Widths, fetch FSM encoding and reset address shared by the
// instruction fetch stage and its testbench
//----------------------------------------------------------------------
package fetch_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    typedef logic [31:0] addr_t;   // Byte address, fetch and redirect
    typedef logic [31:0] word_t;   // Memory data word
    typedef logic [15:0] half_t;   // Buffer storage unit

    // Halfwords held in the fetch buffer, 0 to 7
    typedef logic [2:0]  depth_t;

    // ------------------------------------------------------------------
    // Request FSM
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        FS_IDLE = 2'b00,           // Nothing outstanding
        FS_REQ  = 2'b01,           // Request up, waiting for grant
        FS_RSP  = 2'b10            // Granted, response arrives now
    } fetch_state_t;

    // Boot address of the core
    localparam addr_t PC_RESET_DEFAULT = 32'h8000_0000;

endpackage

//--- hdl/fetch_addr_ctr.sv
//----------------------------------------------------------------------
// Fetch address counter
// Holds the word address of the next instruction memory read and
// moves it on redirects and granted requests
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_addr_ctr #(
    parameter fetch_pkg::addr_t PC_RESET = fetch_pkg::PC_RESET_DEFAULT // Boot address
) (
    input  logic             g_clk,      // Global clock
    input  logic             g_resetn,   // Synchronous reset, active low
    input  logic             cf_take,    // Redirect accepted this cycle
    input  fetch_pkg::addr_t cf_target,  // Redirect target, halfword aligned
    input  logic             req_fire,   // Request granted this cycle
    output fetch_pkg::addr_t fetch_addr  // Address presented to memory
);

    // ------------------------------------------------------------------
    // Next address
    // ------------------------------------------------------------------

    fetch_pkg::addr_t addr_q;    // Current fetch word
    fetch_pkg::addr_t addr_d;
    fetch_pkg::addr_t addr_seq;  // Sequential successor
    fetch_pkg::addr_t addr_tgt;  // Word holding the target

    assign addr_seq = addr_q + 32'd4;                 // One word on
    assign addr_tgt = {cf_target[31:2], 2'b00};       // Drop halfword offset

    always_comb begin
        addr_d = addr_q;                              // Hold until granted
        if (cf_take) begin
            // Redirect wins, even over a grant in the same cycle
            addr_d = addr_tgt;
        end else if (req_fire) begin
            addr_d = addr_seq;
        end
    end

    // ------------------------------------------------------------------
    // Address register
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            addr_q <= PC_RESET;
        end else begin
            addr_q <= addr_d;
        end
    end

    // Memory sees the register directly
    assign fetch_addr = addr_q;

endmodule

//--- hdl/fetch_req_fsm.sv
//----------------------------------------------------------------------
// Fetch request FSM
// Raises instruction memory requests, accepts redirects and steers
// each response into the fetch buffer or drops it
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_req_fsm #(
    parameter int BUF_DEPTH = 6      // Buffer size in halfwords
) (
    input  logic              g_clk,          // Global clock
    input  logic              g_resetn,       // Synchronous reset, active low
    input  logic              cf_req,         // Redirect request
    input  logic              cf_target_half, // Target bit 1
    input  logic              imem_gnt,       // Memory grant
    input  fetch_pkg::depth_t n_depth,        // Buffer depth after consumption
    output logic              imem_req,       // Memory request
    output logic              cf_ack,         // Redirect can be taken
    output logic              cf_take,        // Redirect taken
    output logic              req_fire,       // Request granted
    output logic              store_4byte,    // Keep whole response
    output logic              store_2byte     // Keep upper halfword only
);

    fetch_pkg::fetch_state_t state_q;
    fetch_pkg::fetch_state_t state_d;
    logic       drop_q;        // Next response is stale
    logic       drop_d;
    logic       misaligned_q;  // Next kept response starts at bit 16
    logic       misaligned_d;
    logic       rsp_keep;      // Response written this cycle
    logic [3:0] fill_sum;      // Depth including response in flight
    logic       want_req;

    // ------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------

    assign imem_req = (state_q == fetch_pkg::FS_REQ);
    assign req_fire = imem_req && imem_gnt;
    assign cf_ack   = !imem_req || imem_gnt;      // Nothing pending or leaving now
    assign cf_take  = cf_req && cf_ack;

    // Response belongs to the old path when a redirect lands on it
    assign rsp_keep    = (state_q == fetch_pkg::FS_RSP) && !drop_q && !cf_take;
    assign store_4byte = rsp_keep && !misaligned_q;
    assign store_2byte = rsp_keep && misaligned_q;

    // Room for one more word, counting the response being written
    assign fill_sum = {1'b0, n_depth} + (rsp_keep ? 4'd2 : 4'd0);
    assign want_req = cf_take || (int'(fill_sum) < BUF_DEPTH - 1);

    // ------------------------------------------------------------------
    // Next state and flags
    // ------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::FS_IDLE: begin
                if (want_req) begin
                    state_d = fetch_pkg::FS_REQ;
                end
            end
            fetch_pkg::FS_REQ: begin
                if (imem_gnt) begin
                    state_d = fetch_pkg::FS_RSP;   // Data next cycle
                end
            end
            fetch_pkg::FS_RSP: begin
                state_d = want_req ? fetch_pkg::FS_REQ : fetch_pkg::FS_IDLE;
            end
            default: begin
                state_d = fetch_pkg::FS_IDLE;
            end
        endcase
    end

    always_comb begin
        drop_d = drop_q;
        if (cf_take && req_fire) begin
            drop_d = 1'b1;                         // Granted word is old path
        end else if (state_q == fetch_pkg::FS_RSP) begin
            drop_d = 1'b0;                         // Stale word gone
        end
        misaligned_d = misaligned_q;
        if (cf_take) begin
            misaligned_d = cf_target_half;
        end else if (store_2byte) begin
            misaligned_d = 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q      <= fetch_pkg::FS_IDLE;
            drop_q       <= 1'b0;
            misaligned_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            drop_q       <= drop_d;
            misaligned_q <= misaligned_d;
        end
    end

endmodule

//--- hdl/fetch_buffer.sv
//----------------------------------------------------------------------
// Fetch buffer
// Halfword shift buffer with an error bit per entry; finds the length
// of the head instruction and presents it to decode
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_buffer #(
    parameter int BUF_DEPTH = 6      // Entries in halfwords, 4 to 7
) (
    input  logic              g_clk,        // Global clock
    input  logic              g_resetn,     // Synchronous reset, active low
    input  logic              flush,        // Empty the buffer
    input  logic              store_4byte,  // Append both halfwords
    input  logic              store_2byte,  // Append upper halfword
    input  fetch_pkg::word_t  wdata,        // Memory response data
    input  logic              werror,       // Memory response error
    input  logic              consume,      // Decode takes the head
    output fetch_pkg::depth_t n_depth,      // Depth after consumption
    output logic              instr_valid,  // Whole instruction present
    output fetch_pkg::word_t  instr_data,   // Head instruction
    output logic              instr_error   // Error on any used halfword
);

    fetch_pkg::half_t     buf_q [BUF_DEPTH];  // Entry 0 is the head
    fetch_pkg::half_t     buf_d [BUF_DEPTH];
    logic [BUF_DEPTH-1:0] err_q;
    logic [BUF_DEPTH-1:0] err_d;
    fetch_pkg::depth_t    depth_q;            // Valid entries
    fetch_pkg::depth_t    depth_d;
    fetch_pkg::depth_t    n_used;             // Halfwords leaving
    fetch_pkg::depth_t    n_new;              // Halfwords arriving
    fetch_pkg::half_t     wr_first;           // First halfword appended
    logic                 head_32;            // Head is a 32-bit encoding
    logic                 have_one;
    logic                 have_two;
    logic                 take;               // Head leaves this cycle
    logic                 wr_en;

    // ------------------------------------------------------------------
    // Head instruction
    // ------------------------------------------------------------------

    // Low bits 11 mark a full-size instruction
    assign head_32  = (buf_q[0][1:0] == 2'b11);
    assign have_one = (depth_q != 3'd0);
    assign have_two = (depth_q >= 3'd2);

    assign instr_valid = have_one && (!head_32 || have_two);

    // Compressed form gets a zero upper half
    assign instr_data  = head_32 ? {buf_q[1], buf_q[0]} : {16'h0000, buf_q[0]};
    assign instr_error = head_32 ? (err_q[1] | err_q[0]) : err_q[0];

    // ------------------------------------------------------------------
    // Depth bookkeeping
    // ------------------------------------------------------------------

    assign take = consume && instr_valid;       // Never eat a partial instr

    always_comb begin
        n_used = 3'd0;
        if (take) begin
            n_used = head_32 ? 3'd2 : 3'd1;
        end
        n_new = 3'd0;
        if (store_4byte) begin
            n_new = 3'd2;
        end else if (store_2byte) begin
            n_new = 3'd1;
        end
    end

    assign n_depth = depth_q - n_used;
    assign wr_en   = (store_4byte || store_2byte) && !flush;  // Flush wins

    // Misaligned response keeps only its upper half
    assign wr_first = store_2byte ? wdata[31:16] : wdata[15:0];

    assign depth_d = flush ? 3'd0 : (n_depth + n_new);

    // ------------------------------------------------------------------
    // Shift and append
    // ------------------------------------------------------------------

    always_comb begin
        int src;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            // Move entries down past the consumed head
            src = i + int'(n_used);
            if (src >= BUF_DEPTH) begin
                src = BUF_DEPTH - 1;              // Beyond depth, don't care
            end
            buf_d[i] = buf_q[src];
            err_d[i] = err_q[src];

            // New data lands right behind what remains
            if (wr_en && (i == int'(n_depth))) begin
                buf_d[i] = wr_first;
                err_d[i] = werror;
            end
            if (wr_en && store_4byte && (i == int'(n_depth) + 1)) begin
                buf_d[i] = wdata[31:16];
                err_d[i] = werror;                 // Whole word shares the flag
            end
        end
    end

    // ------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------

    // Halfword and error storage
    always_ff @(posedge g_clk) begin
        buf_q <= buf_d;
        err_q <= err_d;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= 3'd0;
        end else begin
            depth_q <= depth_d;
        end
    end

endmodule

//--- hdl/fetch_stage.sv
//----------------------------------------------------------------------
// Instruction fetch stage
// Reads words from instruction memory, follows redirects and feeds
// decode one 16-bit or 32-bit instruction at a time
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_stage #(
    parameter fetch_pkg::addr_t PC_RESET  = fetch_pkg::PC_RESET_DEFAULT, // Boot address
    parameter int               BUF_DEPTH = 6                            // Buffer halfwords
) (
    input  logic             g_clk,        // Global clock
    input  logic             g_resetn,     // Synchronous reset, active low
    input  logic             cf_req,       // Control flow change
    input  fetch_pkg::addr_t cf_target,    // Change target
    output logic             cf_ack,       // Change accepted when high
    input  logic             flush,        // Drop buffered instructions
    output logic             imem_req,     // Memory read request
    output fetch_pkg::addr_t imem_addr,    // Word aligned read address
    input  logic             imem_gnt,     // Request accepted
    input  fetch_pkg::word_t imem_rdata,   // Read data, cycle after grant
    input  logic             imem_error,   // Read error, cycle after grant
    output logic             instr_valid,  // Decode may take instr_data
    output fetch_pkg::word_t instr_data,   // Next instruction
    output logic             instr_error,  // Fetch error on it
    input  logic             dec_busy      // Decode stall
);

    logic              cf_take;      // Redirect happening now
    logic              req_fire;     // Grant this cycle
    logic              store_4byte;
    logic              store_2byte;
    logic              consume;      // Decode takes the head
    fetch_pkg::depth_t n_depth;

    assign consume = instr_valid && !dec_busy;

    // ------------------------------------------------------------------
    // Submodules
    // ------------------------------------------------------------------

    fetch_addr_ctr #(
        .PC_RESET       (PC_RESET)
    ) i_fetch_addr_ctr (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .cf_take        (cf_take),
        .cf_target      (cf_target),
        .req_fire       (req_fire),
        .fetch_addr     (imem_addr)
    );

    fetch_req_fsm #(
        .BUF_DEPTH      (BUF_DEPTH)
    ) i_fetch_req_fsm (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .cf_req         (cf_req),
        .cf_target_half (cf_target[1]),   // Halfword offset of target
        .imem_gnt       (imem_gnt),
        .n_depth        (n_depth),
        .imem_req       (imem_req),
        .cf_ack         (cf_ack),
        .cf_take        (cf_take),
        .req_fire       (req_fire),
        .store_4byte    (store_4byte),
        .store_2byte    (store_2byte)
    );

    fetch_buffer #(
        .BUF_DEPTH      (BUF_DEPTH)
    ) i_fetch_buffer (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .flush          (flush),
        .store_4byte    (store_4byte),
        .store_2byte    (store_2byte),
        .wdata          (imem_rdata),
        .werror         (imem_error),
        .consume        (consume),
        .n_depth        (n_depth),
        .instr_valid    (instr_valid),
        .instr_data     (instr_data),
        .instr_error    (instr_error)
    );

endmodule

//--- sim/fetch_mem_model.sv
//----------------------------------------------------------------------
// Instruction memory model
// Grants after a pseudo-random delay, answers one cycle after the
// grant with a computed pattern, and flags one error region
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_mem_model #(
    parameter fetch_pkg::addr_t ERR_BASE = 32'h8000_0100  // 64-byte error region
) (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             req,
    input  fetch_pkg::addr_t addr,
    output logic             gnt,
    output fetch_pkg::word_t rdata,
    output logic             error
);

    logic [31:0] lcg_q;     // Delay generator state
    logic [31:0] lcg_n;
    int          delay_q;   // Grant delay of the current request
    int          wait_q;    // Cycles waited so far

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Each halfword is its byte address XOR 5A5A, 32-bit marks on bit 2
    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t a);
        fetch_pkg::half_t lo;
        fetch_pkg::half_t hi;
        lo = {a[15:2], 2'b00} ^ 16'h5A5A;
        hi = {a[15:2], 2'b10} ^ 16'h5A5A;
        if (a[2]) begin
            lo[1:0] = 2'b11;
            hi[1:0] = 2'b11;
        end
        return {hi, lo};
    endfunction

    assign lcg_n = lcg_next(lcg_q);
    assign gnt   = req && (wait_q >= delay_q);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lcg_q   <= 32'd3;            // Seed
            delay_q <= 0;
            wait_q  <= 0;
            rdata   <= '0;
            error   <= 1'b0;
        end else if (gnt) begin
            lcg_q   <= lcg_n;
            delay_q <= int'((lcg_n >> 16) % 32'd3);   // 0 to 2 cycles
            wait_q  <= 0;
            rdata   <= mem_word(addr);
            error   <= (addr[31:6] == ERR_BASE[31:6]);
        end else if (req) begin
            wait_q  <= wait_q + 1;
        end
    end

endmodule

//--- sim/fetch_stage_tb.sv
//----------------------------------------------------------------------
// Fetch stage testbench
// Table of redirects and decode stalls, checked against a reference
// walker over the memory data rule
//----------------------------------------------------------------------
`timescale 1ns/10ps

module fetch_stage_tb;

    localparam fetch_pkg::addr_t PC_RESET = 32'h8000_0000;
    localparam fetch_pkg::addr_t ERR_BASE = 32'h8000_0100;
    localparam int               N_ROWS   = 9;

    logic             g_clk;
    logic             g_resetn;
    logic             cf_req;
    fetch_pkg::addr_t cf_target;
    logic             cf_ack;
    logic             flush;
    logic             imem_req;
    fetch_pkg::addr_t imem_addr;
    logic             imem_gnt;
    fetch_pkg::word_t imem_rdata;
    logic             imem_error;
    logic             instr_valid;
    fetch_pkg::word_t instr_data;
    logic             instr_error;
    logic             dec_busy;

    // Stimulus table
    logic             row_redir [N_ROWS];
    fetch_pkg::addr_t row_target [N_ROWS];
    int               row_count [N_ROWS];   // Instructions to consume
    int               row_hold [N_ROWS];    // Busy cycles before consuming
    logic [7:0]       row_mask [N_ROWS];    // Busy pattern, cycled

    fetch_pkg::addr_t ref_pc;        // Walker position
    fetch_pkg::addr_t exp_addr;      // Next granted address
    fetch_pkg::word_t prev_data;
    logic             prev_hold;     // Stalled valid instr last cycle
    int               consumed;
    int               cycle_cnt;
    int               cycle_limit;

    fetch_stage #(
        .PC_RESET    (PC_RESET),
        .BUF_DEPTH   (6)
    ) i_fetch_stage (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .cf_req      (cf_req),
        .cf_target   (cf_target),
        .cf_ack      (cf_ack),
        .flush       (flush),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_gnt    (imem_gnt),
        .imem_rdata  (imem_rdata),
        .imem_error  (imem_error),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_error (instr_error),
        .dec_busy    (dec_busy)
    );

    fetch_mem_model #(
        .ERR_BASE (ERR_BASE)
    ) i_mem (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .req      (imem_req),
        .addr     (imem_addr),
        .gnt      (imem_gnt),
        .rdata    (imem_rdata),
        .error    (imem_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------
    // Reference walker
    // ------------------------------------------------------------------

    function automatic fetch_pkg::half_t ref_half(input fetch_pkg::addr_t a);
        fetch_pkg::half_t h;
        h = {a[15:1], 1'b0} ^ 16'h5A5A;
        if (a[2]) h[1:0] = 2'b11;                 // Upper word of 8 bytes
        return h;
    endfunction

    function automatic logic ref_err(input fetch_pkg::addr_t a);
        return a[31:6] == ERR_BASE[31:6];
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_word(input fetch_pkg::word_t got, input fetch_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_addr(input fetch_pkg::addr_t got, input fetch_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // One clock cycle: drive, settle, check
    // ------------------------------------------------------------------

    task automatic run_cycle(input logic busy, input logic redir,
                             input fetch_pkg::addr_t tgt, output logic took);
        fetch_pkg::word_t exp_data;
        logic             exp_err;
        logic             pending;
        fetch_pkg::half_t h0;
        @(posedge g_clk);
        #1;
        dec_busy  = busy;
        cf_req    = redir;
        cf_target = tgt;
        flush     = 1'b0;
        #1;
        if (prev_hold) begin
            check_flag(instr_valid, 1'b1, "instr_valid during stall");
            check_word(instr_data, prev_data, "instr_data during stall");
        end
        if (imem_req && imem_gnt) begin
            check_addr(imem_addr, exp_addr, "imem_addr at grant");
            exp_addr = exp_addr + 32'd4;
        end
        // Redirect port is open unless a request still waits for its grant
        pending = imem_req && !imem_gnt;
        check_flag(cf_ack, !pending, "cf_ack");
        took = redir && cf_ack;
        if (took) begin
            flush    = 1'b1;                      // Same edge as the redirect
            exp_addr = {tgt[31:2], 2'b00};
        end
        if (instr_valid && !busy) begin
            h0 = ref_half(ref_pc);
            if (h0[1:0] == 2'b11) begin
                exp_data = {ref_half(ref_pc + 32'd2), h0};
                exp_err  = ref_err(ref_pc) | ref_err(ref_pc + 32'd2);
                ref_pc   = ref_pc + 32'd4;
            end else begin
                exp_data = {16'h0000, h0};
                exp_err  = ref_err(ref_pc);
                ref_pc   = ref_pc + 32'd2;
            end
            check_word(instr_data, exp_data, "instr_data");
            check_flag(instr_error, exp_err, "instr_error");
            consumed++;
        end
        prev_hold = instr_valid && busy && !took;
        prev_data = instr_data;
    endtask

    task automatic load_table();
        // redirect, target, count, hold, busy mask
        row_redir = '{0, 1, 1, 1, 0, 1, 1, 1, 0};
        row_target = '{32'h0, 32'h8000_0040, 32'h8000_0086, 32'h8000_00A2, 32'h0,
                       32'h8000_00F8, 32'h8000_00FE, 32'h8000_013E, 32'h0};
        row_count = '{12, 8, 6, 6, 10, 40, 6, 4, 8};
        row_hold  = '{0, 0, 0, 0, 25, 0, 0, 0, 12};
        row_mask  = '{8'h00, 8'h24, 8'h00, 8'h11, 8'h00, 8'h6C, 8'h00, 8'h02, 8'hAA};
    endtask

    // Timeout guard
    always @(posedge g_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout, instruction stream stopped");
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int   start;
        int   cyc;
        logic took;
        g_resetn    = 1'b0;
        cf_req      = 1'b0;
        cf_target   = '0;
        flush       = 1'b0;
        dec_busy    = 1'b0;
        ref_pc      = PC_RESET;
        exp_addr    = PC_RESET;
        prev_hold   = 1'b0;
        prev_data   = '0;
        consumed    = 0;
        cycle_cnt   = 0;
        load_table();
        cycle_limit = 20;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit += 40 * row_count[r];
        end
        repeat (5) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            if (row_redir[r]) begin
                took = 1'b0;
                while (!took) begin
                    run_cycle(1'b1, 1'b1, row_target[r], took);
                end
                ref_pc = row_target[r];          // New path starts here
            end
            for (int h = 0; h < row_hold[r]; h++) begin
                run_cycle(1'b1, 1'b0, '0, took);
            end
            if (row_hold[r] > 0) begin
                // Buffer full, so no request stays up
                check_flag(imem_req, 1'b0, "imem_req with full buffer");
                check_flag(instr_valid, 1'b1, "instr_valid after stall");
            end
            start = consumed;
            cyc   = 0;
            while (consumed - start < row_count[r]) begin
                run_cycle(row_mask[r][cyc % 8], 1'b0, '0, took);
                cyc++;
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- compile.f
hdl/fetch_pkg.sv
hdl/fetch_addr_ctr.sv
hdl/fetch_req_fsm.sv
hdl/fetch_buffer.sv
hdl/fetch_stage.sv
sim/fetch_mem_model.sv
sim/fetch_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f \
    --top-module fetch_stage_tb -o fetch_stage_sim \
    && ./obj_dir/fetch_stage_sim \
    || exit 1
